// File: rtl/cp0_pkg.sv
`default_nettype none

package cp0_pkg;

	typedef logic [31:0] word_t;
	typedef logic        u1;
	typedef logic [4:0]  u5;
	typedef logic [5:0]  u6;
	typedef logic [7:0]  u8;

	// register number in the upper bits, select below
	typedef struct packed {
		u5          num;
		logic [2:0] sel;
	} cp0_addr_t;

	localparam u5 REG_INDEX     = 5'd0;
	localparam u5 REG_ENTRY_LO0 = 5'd2;
	localparam u5 REG_ENTRY_LO1 = 5'd3;
	localparam u5 REG_CONTEXT   = 5'd4;
	localparam u5 REG_PAGE_MASK = 5'd5;
	localparam u5 REG_WIRED     = 5'd6;
	localparam u5 REG_BAD_VADDR = 5'd8;
	localparam u5 REG_COUNT     = 5'd9;
	localparam u5 REG_ENTRY_HI  = 5'd10;
	localparam u5 REG_COMPARE   = 5'd11;
	localparam u5 REG_STATUS    = 5'd12;
	localparam u5 REG_CAUSE     = 5'd13;
	localparam u5 REG_EPC       = 5'd14;
	localparam u5 REG_PRID      = 5'd15;
	localparam u5 REG_CONFIG    = 5'd16;

	localparam word_t PRID_VALUE   = 32'h0000_4220;
	localparam word_t CONFIG_RESET = 32'h8000_0080;

	// writable bits per register
	localparam word_t MASK_ENTRY_LO = 32'h3fff_ffff;
	localparam word_t MASK_CONTEXT  = 32'hff80_0000;
	localparam word_t MASK_ENTRY_HI = 32'hffff_e0ff;
	localparam word_t MASK_STATUS   = 32'h1040_ff17;
	localparam word_t MASK_CAUSE    = 32'h0080_0300;

	localparam u5 EXCCODE_INT  = 5'h00;
	localparam u5 EXCCODE_ADEL = 5'h04;
	localparam u5 EXCCODE_ADES = 5'h05;
	localparam u5 EXCCODE_SYS  = 5'h08;
	localparam u5 EXCCODE_BP   = 5'h09;
	localparam u5 EXCCODE_RI   = 5'h0a;
	localparam u5 EXCCODE_OV   = 5'h0c;

	typedef struct packed {
		logic [2:0] rsvd31;
		u1          cu0;
		logic [4:0] rsvd27;
		u1          bev;
		logic [5:0] rsvd21;
		u8          im;
		logic [2:0] rsvd7;
		u1          um;
		u1          rsvd3;
		u1          erl;
		u1          exl;
		u1          ie;
	} status_fields_t;

	typedef union packed {
		word_t          w;
		status_fields_t f;
	} status_u;

	typedef struct packed {
		u1          bd;
		u1          ti;
		logic [5:0] rsvd29;
		u1          iv;
		logic [6:0] rsvd22;
		u8          ip;
		u1          rsvd7;
		u5          exc_code;
		logic [1:0] rsvd1;
	} cause_fields_t;

	typedef union packed {
		word_t         w;
		cause_fields_t f;
	} cause_u;

	typedef enum logic [1:0] {
		NONE,
		EXCEPTION,
		ERET_OP
	} ctype_t;

	typedef struct packed {
		u1 bad_vaddr_f;
		u1 reserve_instr;
		u1 overflow;
		u1 trap;
		u1 syscall;
		u1 adel_d;
		u1 ades_d;
	} excp_flags_t;

	// write request, already qualified by select and commit
	typedef struct packed {
		u1     en;
		u5     addr;
		word_t data;
	} cp0_wr_t;

	typedef struct packed {
		u1 take;
		u1 is_int;
		u5 code;
		u1 bad_we;
		u1 bad_from_pc;
	} excp_commit_t;

endpackage

`default_nettype wire

// File: rtl/cp0_excp_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_excp_encoder (
	input  cp0_pkg::ctype_t       ctype,
	input  cp0_pkg::excp_flags_t  etype,
	input  cp0_pkg::u1            int_take,
	output cp0_pkg::excp_commit_t commit
);

	always_comb begin
		commit = '0;
		commit.take = (ctype == cp0_pkg::EXCEPTION) || int_take;
		commit.is_int = int_take;
		// interrupt wins over every synchronous flag
		if (int_take) begin
			commit.code = cp0_pkg::EXCCODE_INT;
		end else if (etype.bad_vaddr_f) begin
			// fetch fault, address is the pc itself
			commit.code = cp0_pkg::EXCCODE_ADEL;
			commit.bad_we = 1'b1;
			commit.bad_from_pc = 1'b1;
		end else if (etype.reserve_instr) begin
			commit.code = cp0_pkg::EXCCODE_RI;
		end else if (etype.overflow) begin
			commit.code = cp0_pkg::EXCCODE_OV;
		end else if (etype.trap) begin
			commit.code = cp0_pkg::EXCCODE_BP;
		end else if (etype.syscall) begin
			commit.code = cp0_pkg::EXCCODE_SYS;
		end else if (etype.adel_d) begin
			commit.code = cp0_pkg::EXCCODE_ADEL;
			commit.bad_we = 1'b1;
		end else if (etype.ades_d) begin
			commit.code = cp0_pkg::EXCCODE_ADES;
			commit.bad_we = 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/cp0_int_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_int_ctrl (
	input  logic             clk,
	input  logic             reset,
	input  cp0_pkg::status_u status,
	input  cp0_pkg::cause_u  cause,
	input  cp0_pkg::u1       ti,
	input  cp0_pkg::u6       ext_int,
	input  cp0_pkg::u1       inter_valid,
	output cp0_pkg::u1       int_take,
	output cp0_pkg::u1       int_pending
);

	cp0_pkg::u8 lines;
	cp0_pkg::u1 int_raw;

	// timer shares line 7 with the top external pin
	assign lines = {ext_int, cause.f.ip[1:0]} | {ti, 7'b0};

	assign int_raw = status.f.ie && !status.f.exl && (|(lines & status.f.im));

	// pipeline not ready, so hold it until it is
	always_ff @(posedge clk) begin
		if (reset) begin
			int_pending <= 1'b0;
		end else if (inter_valid) begin
			int_pending <= 1'b0;
		end else if (int_raw) begin
			int_pending <= 1'b1;
		end
	end

	assign int_take = (int_raw || int_pending) && inter_valid;

endmodule

`default_nettype wire

// File: rtl/cp0_timer.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_timer (
	input  logic             clk,
	input  logic             reset,
	input  cp0_pkg::cp0_wr_t wr,
	output cp0_pkg::word_t   count,
	output cp0_pkg::word_t   compare,
	output cp0_pkg::u1       ti
);

	cp0_pkg::u1 tick;
	cp0_pkg::u1 count_we;
	cp0_pkg::u1 compare_we;

	assign count_we = wr.en && (wr.addr == cp0_pkg::REG_COUNT);
	assign compare_we = wr.en && (wr.addr == cp0_pkg::REG_COMPARE);

	// half rate, low right after reset
	always_ff @(posedge clk) begin
		if (reset) begin
			tick <= 1'b0;
		end else begin
			tick <= !tick;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			compare <= '0;
		end else begin
			// software load beats the increment
			if (count_we) begin
				count <= wr.data;
			end else if (tick) begin
				count <= count + 32'd1;
			end
			if (compare_we) begin
				compare <= wr.data;
			end
		end
	end

	// sticky until software rewrites compare
	always_ff @(posedge clk) begin
		if (reset) begin
			ti <= 1'b0;
		end else if (compare_we) begin
			ti <= 1'b0;
		end else if (count == compare) begin
			ti <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/cp0_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_regfile (
	input  logic                  clk,
	input  logic                  reset,
	input  cp0_pkg::cp0_addr_t    ra,
	input  cp0_pkg::cp0_addr_t    wa,
	input  cp0_pkg::word_t        wd,
	input  cp0_pkg::u1            valid,
	input  cp0_pkg::u1            is_eret,
	input  cp0_pkg::word_t        pc,
	input  cp0_pkg::word_t        vaddr,
	input  cp0_pkg::word_t        int_pc,
	input  cp0_pkg::u1            is_slot,
	input  cp0_pkg::excp_commit_t commit,
	input  cp0_pkg::word_t        count,
	input  cp0_pkg::word_t        compare,
	input  cp0_pkg::u1            ti,
	input  cp0_pkg::u6            int_hw,
	output cp0_pkg::word_t        rd,
	output cp0_pkg::cp0_wr_t      wr,
	output cp0_pkg::status_u      status,
	output cp0_pkg::cause_u       cause,
	output cp0_pkg::word_t        epc
);

	cp0_pkg::word_t  index_q;
	cp0_pkg::word_t  entry_lo0_q;
	cp0_pkg::word_t  entry_lo1_q;
	cp0_pkg::word_t  ctx_q;
	cp0_pkg::word_t  page_mask_q;
	cp0_pkg::word_t  wired_q;
	cp0_pkg::word_t  bad_vaddr_q;
	cp0_pkg::word_t  entry_hi_q;
	cp0_pkg::status_u status_q;
	cp0_pkg::cause_u cause_q;
	cp0_pkg::word_t  epc_q;

	function automatic cp0_pkg::word_t merge(input cp0_pkg::word_t old_val,
			input cp0_pkg::word_t new_val, input cp0_pkg::word_t mask);
		merge = (old_val & ~mask) | (new_val & mask);
	endfunction

	// only sel 0 is implemented, an exception drops the write
	assign wr.en = valid && (wa.sel == 3'b0) && !commit.take;
	assign wr.addr = wa.num;
	assign wr.data = wd;

	// hardware lines and timer bit are not stored
	always_comb begin
		cause = cause_q;
		cause.f.ip[7:2] = int_hw;
		cause.f.ti = ti;
	end

	assign status = status_q;
	assign epc = epc_q;

	always_comb begin
		rd = '0;
		if (ra.sel == 3'b0) begin
			case (ra.num)
				cp0_pkg::REG_INDEX:     rd = index_q;
				cp0_pkg::REG_ENTRY_LO0: rd = entry_lo0_q;
				cp0_pkg::REG_ENTRY_LO1: rd = entry_lo1_q;
				cp0_pkg::REG_CONTEXT:   rd = ctx_q;
				cp0_pkg::REG_PAGE_MASK: rd = page_mask_q;
				cp0_pkg::REG_WIRED:     rd = wired_q;
				cp0_pkg::REG_BAD_VADDR: rd = bad_vaddr_q;
				cp0_pkg::REG_COUNT:     rd = count;
				cp0_pkg::REG_ENTRY_HI:  rd = entry_hi_q;
				cp0_pkg::REG_COMPARE:   rd = compare;
				cp0_pkg::REG_STATUS:    rd = status_q.w;
				cp0_pkg::REG_CAUSE:     rd = cause.w;
				cp0_pkg::REG_EPC:       rd = epc_q;
				cp0_pkg::REG_PRID:      rd = cp0_pkg::PRID_VALUE;
				cp0_pkg::REG_CONFIG:    rd = cp0_pkg::CONFIG_RESET;
				default:                rd = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			index_q <= '0;
			entry_lo0_q <= '0;
			entry_lo1_q <= '0;
			ctx_q <= '0;
			page_mask_q <= '0;
			wired_q <= '0;
			bad_vaddr_q <= '0;
			entry_hi_q <= '0;
			status_q <= '0;
			cause_q <= '0;
			epc_q <= '0;
		end else begin
			// count and compare live in the timer
			if (wr.en) begin
				case (wr.addr)
					cp0_pkg::REG_INDEX:     index_q <= wr.data;
					cp0_pkg::REG_ENTRY_LO0:
						entry_lo0_q <= merge(entry_lo0_q, wr.data, cp0_pkg::MASK_ENTRY_LO);
					cp0_pkg::REG_ENTRY_LO1:
						entry_lo1_q <= merge(entry_lo1_q, wr.data, cp0_pkg::MASK_ENTRY_LO);
					cp0_pkg::REG_CONTEXT:
						ctx_q <= merge(ctx_q, wr.data, cp0_pkg::MASK_CONTEXT);
					cp0_pkg::REG_PAGE_MASK: page_mask_q <= wr.data;
					cp0_pkg::REG_WIRED:     wired_q <= wr.data;
					cp0_pkg::REG_ENTRY_HI:
						entry_hi_q <= merge(entry_hi_q, wr.data, cp0_pkg::MASK_ENTRY_HI);
					cp0_pkg::REG_STATUS:
						status_q.w <= merge(status_q.w, wr.data, cp0_pkg::MASK_STATUS);
					cp0_pkg::REG_CAUSE:
						cause_q.w <= merge(cause_q.w, wr.data, cp0_pkg::MASK_CAUSE);
					cp0_pkg::REG_EPC:       epc_q <= wr.data;
					default: ;
				endcase
			end
			if (commit.take) begin
				cause_q.f.exc_code <= commit.code;
				if (commit.bad_we) begin
					bad_vaddr_q <= commit.bad_from_pc ? pc : vaddr;
				end
				// nested exception keeps the first return point
				if (!status_q.f.exl) begin
					if (commit.is_int) begin
						epc_q <= int_pc;
					end else if (is_slot) begin
						epc_q <= pc - 32'd4;
					end else begin
						epc_q <= pc;
					end
					cause_q.f.bd <= is_slot;
				end
				status_q.f.exl <= 1'b1;
			end
			// eret last so it clears exl over a commit
			if (is_eret) begin
				status_q.f.exl <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/cp0_top.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_top (
	input  logic                 clk,
	input  logic                 reset,
	input  cp0_pkg::cp0_addr_t   ra,
	output cp0_pkg::word_t       rd,
	input  cp0_pkg::u1           valid,
	input  cp0_pkg::cp0_addr_t   wa,
	input  cp0_pkg::word_t       wd,
	input  cp0_pkg::ctype_t      ctype,
	input  cp0_pkg::excp_flags_t etype,
	input  cp0_pkg::word_t       pc,
	input  cp0_pkg::word_t       vaddr,
	input  cp0_pkg::u1           is_slot,
	input  cp0_pkg::word_t       int_pc,
	input  cp0_pkg::u1           is_eret,
	input  cp0_pkg::u1           inter_valid,
	input  cp0_pkg::u6           ext_int,
	output cp0_pkg::word_t       epc,
	output cp0_pkg::u1           is_intexc,
	output cp0_pkg::u1           is_exc
);

	cp0_pkg::cp0_wr_t      wr;
	cp0_pkg::status_u      status;
	cp0_pkg::cause_u       cause;
	cp0_pkg::excp_commit_t commit;
	cp0_pkg::word_t        count;
	cp0_pkg::word_t        compare;
	cp0_pkg::u1            ti;
	cp0_pkg::u1            int_take;

	cp0_regfile u_regfile (
		.clk(clk), .reset(reset), .ra(ra), .wa(wa), .wd(wd), .valid(valid),
		.is_eret(is_eret), .pc(pc), .vaddr(vaddr), .int_pc(int_pc), .is_slot(is_slot),
		.commit(commit), .count(count), .compare(compare), .ti(ti), .int_hw(ext_int),
		.rd(rd), .wr(wr), .status(status), .cause(cause), .epc(epc)
	);

	cp0_timer u_timer (
		.clk(clk), .reset(reset), .wr(wr), .count(count), .compare(compare), .ti(ti)
	);

	cp0_int_ctrl u_int_ctrl (
		.clk(clk), .reset(reset), .status(status), .cause(cause), .ti(ti),
		.ext_int(ext_int), .inter_valid(inter_valid),
		.int_take(int_take), .int_pending()
	);

	cp0_excp_encoder u_excp_encoder (
		.ctype(ctype), .etype(etype), .int_take(int_take), .commit(commit)
	);

	assign is_intexc = commit.take;
	assign is_exc = (ctype == cp0_pkg::EXCEPTION);

endmodule

`default_nettype wire

// File: testbench/cp0_sva.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_sva (
	input logic             clk,
	input logic             reset,
	input cp0_pkg::u1       is_exc,
	input cp0_pkg::u1       is_intexc,
	input cp0_pkg::u1       exl,
	input cp0_pkg::cp0_wr_t wr,
	input cp0_pkg::word_t   count
);

	assert property (@(posedge clk) disable iff (reset) is_exc |-> is_intexc)
		else $error("is_exc without is_intexc");

	// mtc0 to status may also set exl
	assert property (@(posedge clk) disable iff (reset)
		$rose(exl) |-> $past(is_intexc) ||
			$past(wr.en && wr.addr == cp0_pkg::REG_STATUS))
		else $error("exl rose without a commit");

	assert property (@(posedge clk) disable iff (reset)
		!$past(wr.en && wr.addr == cp0_pkg::REG_COUNT) |-> (count - $past(count)) <= 32'd1)
		else $error("count jumped by more than one");

endmodule

bind cp0_top cp0_sva u_sva (
	.clk(clk), .reset(reset), .is_exc(is_exc), .is_intexc(is_intexc),
	.exl(status.f.exl), .wr(wr), .count(count)
);

`default_nettype wire

// File: testbench/cp0_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_tb;

	typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_EXC} op_t;

	typedef struct packed {
		op_t                  op;
		cp0_pkg::u5           addr;
		cp0_pkg::word_t       data;
		cp0_pkg::excp_flags_t flags;
		cp0_pkg::word_t       expected;
	} row_t;

	logic clk;
	logic reset;
	cp0_pkg::cp0_addr_t   ra;
	cp0_pkg::word_t       rd;
	cp0_pkg::u1           valid;
	cp0_pkg::cp0_addr_t   wa;
	cp0_pkg::word_t       wd;
	cp0_pkg::ctype_t      ctype;
	cp0_pkg::excp_flags_t etype;
	cp0_pkg::word_t       pc;
	cp0_pkg::word_t       vaddr;
	cp0_pkg::u1           is_slot;
	cp0_pkg::word_t       int_pc;
	cp0_pkg::u1           is_eret;
	cp0_pkg::u1           inter_valid;
	cp0_pkg::u6           ext_int;
	cp0_pkg::word_t       epc;
	cp0_pkg::u1           is_intexc;
	cp0_pkg::u1           is_exc;

	logic [31:0] lfsr_state;
	row_t rows[$];
	cp0_pkg::word_t bad_model;

	cp0_top uut (
		.clk(clk), .reset(reset), .ra(ra), .rd(rd), .valid(valid), .wa(wa), .wd(wd),
		.ctype(ctype), .etype(etype), .pc(pc), .vaddr(vaddr), .is_slot(is_slot),
		.int_pc(int_pc), .is_eret(is_eret), .inter_valid(inter_valid), .ext_int(ext_int),
		.epc(epc), .is_intexc(is_intexc), .is_exc(is_exc)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// galois form, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
		end
		return r;
	endfunction

	function automatic cp0_pkg::u5 expected_code(input cp0_pkg::excp_flags_t f);
		if (f.bad_vaddr_f) return cp0_pkg::EXCCODE_ADEL;
		if (f.reserve_instr) return cp0_pkg::EXCCODE_RI;
		if (f.overflow) return cp0_pkg::EXCCODE_OV;
		if (f.trap) return cp0_pkg::EXCCODE_BP;
		if (f.syscall) return cp0_pkg::EXCCODE_SYS;
		if (f.adel_d) return cp0_pkg::EXCCODE_ADEL;
		if (f.ades_d) return cp0_pkg::EXCCODE_ADES;
		return cp0_pkg::EXCCODE_INT;
	endfunction

	// writable status fields
	function automatic cp0_pkg::word_t status_mask();
		cp0_pkg::status_u m;
		m.w = '0;
		m.f.cu0 = 1'b1;
		m.f.bev = 1'b1;
		m.f.im = 8'hff;
		m.f.um = 1'b1;
		m.f.erl = 1'b1;
		m.f.exl = 1'b1;
		m.f.ie = 1'b1;
		return m.w;
	endfunction

	// only iv and the two software lines
	function automatic cp0_pkg::word_t cause_mask();
		cp0_pkg::cause_u m;
		m.w = '0;
		m.f.iv = 1'b1;
		m.f.ip[1:0] = 2'b11;
		return m.w;
	endfunction

	task automatic fail_now();
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_word(input string what, input cp0_pkg::word_t got,
			input cp0_pkg::word_t exp);
		if (got !== exp) begin
			$display("ERR %0t %s: got %h expected %h", $time, what, got, exp);
			fail_now();
		end
	endtask

	task automatic check_cause(input cp0_pkg::cause_u got, input cp0_pkg::cause_u exp);
		if (got !== exp) begin
			$display("ERR %0t cause: got %h expected %h (code %h/%h bd %b/%b)", $time,
				got.w, exp.w, got.f.exc_code, exp.f.exc_code, got.f.bd, exp.f.bd);
			fail_now();
		end
	endtask

	task automatic check_bit(input string what, input cp0_pkg::u1 got, input cp0_pkg::u1 exp);
		if (got !== exp) begin
			$display("ERR %0t %s: got %b expected %b", $time, what, got, exp);
			fail_now();
		end
	endtask

	task automatic write_reg(input cp0_pkg::u5 num, input cp0_pkg::word_t data);
		@(negedge clk);
		valid = 1'b1;
		wa = '{num: num, sel: 3'b0};
		wd = data;
		@(negedge clk);
		valid = 1'b0;
	endtask

	task automatic read_reg(input cp0_pkg::u5 num, output cp0_pkg::word_t data);
		ra = '{num: num, sel: 3'b0};
		#1;
		data = rd;
	endtask

	// samples just after each falling edge
	task automatic wait_intexc(input int limit);
		int n;
		n = 0;
		#1;
		while (is_intexc !== 1'b1) begin
			if (n == limit) begin
				$display("interrupt was not taken before the timeout");
				fail_now();
			end
			@(negedge clk);
			#1;
			n++;
		end
	endtask

	task automatic add_row(input op_t op, input cp0_pkg::u5 addr, input cp0_pkg::word_t data,
			input cp0_pkg::excp_flags_t flags, input cp0_pkg::word_t expected);
		rows.push_back('{op: op, addr: addr, data: data, flags: flags, expected: expected});
	endtask

	task automatic add_write(input cp0_pkg::u5 addr, input cp0_pkg::word_t mask);
		cp0_pkg::word_t d;
		d = rand_bits(32);
		add_row(OP_WRITE, addr, d, '0, d & mask);
	endtask

	task automatic apply_row(input row_t r);
		cp0_pkg::word_t got;
		cp0_pkg::cause_u exp_cause;
		cp0_pkg::u1 slot;
		cp0_pkg::word_t va;
		cp0_pkg::word_t exp_epc;
		case (r.op)
			OP_WRITE, OP_READ: begin
				if (r.op == OP_WRITE) write_reg(r.addr, r.data);
				read_reg(r.addr, got);
				if (r.addr == cp0_pkg::REG_CAUSE) check_cause(got, r.expected);
				else check_word("mfc0 read", got, r.expected);
			end
			OP_EXC: begin
				write_reg(cp0_pkg::REG_STATUS, '0);
				slot = 1'(rand_bits(1));
				va = rand_bits(32);
				ctype = cp0_pkg::EXCEPTION;
				etype = r.flags;
				pc = r.data;
				vaddr = va;
				is_slot = slot;
				#1;
				check_bit("is_exc", is_exc, 1'b1);
				check_bit("is_intexc", is_intexc, 1'b1);
				@(negedge clk);
				ctype = cp0_pkg::NONE;
				etype = '0;
				// only the winning exception loads badvaddr
				if (r.flags.bad_vaddr_f) begin
					bad_model = r.data;
				end else if (r.expected[4:0] == cp0_pkg::EXCCODE_ADEL ||
						r.expected[4:0] == cp0_pkg::EXCCODE_ADES) begin
					bad_model = va;
				end
				exp_epc = slot ? r.data - 32'd4 : r.data;
				exp_cause.w = '0;
				exp_cause.f.bd = slot;
				exp_cause.f.exc_code = r.expected[4:0];
				read_reg(cp0_pkg::REG_CAUSE, got);
				check_cause(got, exp_cause);
				read_reg(cp0_pkg::REG_BAD_VADDR, got);
				check_word("badvaddr", got, bad_model);
				read_reg(cp0_pkg::REG_EPC, got);
				check_word("epc", got, exp_epc);
				check_word("epc output", epc, exp_epc);
			end
			default: ;
		endcase
	endtask

	initial begin
		cp0_pkg::word_t got;
		cp0_pkg::word_t n_val;
		cp0_pkg::word_t saved_epc;
		cp0_pkg::cause_u c;
		cp0_pkg::excp_flags_t f;
		lfsr_state = 32'h8af9d95d;
		bad_model = '0;
		reset = 1'b1;
		ra = '0;
		valid = 1'b0;
		wa = '0;
		wd = '0;
		ctype = cp0_pkg::NONE;
		etype = '0;
		pc = '0;
		vaddr = '0;
		is_slot = 1'b0;
		int_pc = '0;
		is_eret = 1'b0;
		inter_valid = 1'b0;
		ext_int = '0;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		// park compare far away to drop the reset-time match
		write_reg(cp0_pkg::REG_COMPARE, 32'hffff_0000);

		add_write(cp0_pkg::REG_INDEX, 32'hffff_ffff);
		add_write(cp0_pkg::REG_ENTRY_LO0, cp0_pkg::MASK_ENTRY_LO);
		add_write(cp0_pkg::REG_ENTRY_LO1, cp0_pkg::MASK_ENTRY_LO);
		add_write(cp0_pkg::REG_CONTEXT, cp0_pkg::MASK_CONTEXT);
		add_write(cp0_pkg::REG_PAGE_MASK, 32'hffff_ffff);
		add_write(cp0_pkg::REG_WIRED, 32'hffff_ffff);
		add_write(cp0_pkg::REG_ENTRY_HI, cp0_pkg::MASK_ENTRY_HI);
		add_write(cp0_pkg::REG_EPC, 32'hffff_ffff);
		add_write(cp0_pkg::REG_CAUSE, cause_mask());
		add_write(cp0_pkg::REG_STATUS, status_mask());
		add_row(OP_READ, 5'd1, '0, '0, '0);
		add_row(OP_READ, cp0_pkg::REG_PRID, '0, '0, cp0_pkg::PRID_VALUE);
		add_row(OP_READ, cp0_pkg::REG_CONFIG, '0, '0, cp0_pkg::CONFIG_RESET);
		add_row(OP_WRITE, cp0_pkg::REG_CAUSE, '0, '0, '0);
		for (int i = 0; i < 12; i++) begin
			f = 7'(rand_bits(7));
			add_row(OP_EXC, '0, rand_bits(32), f, {27'b0, expected_code(f)});
		end
		foreach (rows[i]) apply_row(rows[i]);

		// nested exception while exl is still set
		read_reg(cp0_pkg::REG_EPC, saved_epc);
		@(negedge clk);
		ctype = cp0_pkg::EXCEPTION;
		etype = 7'b0100000;
		pc = saved_epc + 32'h100;
		@(negedge clk);
		ctype = cp0_pkg::NONE;
		etype = '0;
		read_reg(cp0_pkg::REG_EPC, got);
		check_word("epc under exl", got, saved_epc);
		@(negedge clk);
		is_eret = 1'b1;
		@(negedge clk);
		is_eret = 1'b0;
		read_reg(cp0_pkg::REG_STATUS, got);
		check_bit("exl after eret", got[1], 1'b0);

		// external interrupt held until the pipeline is ready
		write_reg(cp0_pkg::REG_STATUS, 32'h0000_ff01);
		ext_int = 6'b000001;
		int_pc = 32'hbfc0_1230;
		repeat (3) begin
			@(negedge clk);
			#1;
			check_bit("is_intexc without inter_valid", is_intexc, 1'b0);
		end
		@(negedge clk);
		inter_valid = 1'b1;
		wait_intexc(4);
		check_bit("is_exc on interrupt", is_exc, 1'b0);
		@(negedge clk);
		inter_valid = 1'b0;
		ext_int = '0;
		check_word("epc output on interrupt", epc, 32'hbfc0_1230);
		read_reg(cp0_pkg::REG_EPC, got);
		check_word("epc of interrupt", got, 32'hbfc0_1230);
		read_reg(cp0_pkg::REG_CAUSE, c);
		check_word("interrupt exccode", {27'b0, c.f.exc_code}, {27'b0, cp0_pkg::EXCCODE_INT});

		// count runs at half rate
		n_val = rand_bits(32) & 32'h7fff_ffff;
		write_reg(cp0_pkg::REG_COUNT, n_val);
		read_reg(cp0_pkg::REG_COUNT, got);
		check_word("count load", got, n_val);
		for (int t = 0; t < 4 && got == n_val; t++) begin
			@(negedge clk);
			read_reg(cp0_pkg::REG_COUNT, got);
		end
		check_word("count first step", got, n_val + 32'd1);
		for (int k = 1; k <= 5; k++) begin
			repeat (2) @(negedge clk);
			read_reg(cp0_pkg::REG_COUNT, got);
			check_word("count after 2k cycles", got, n_val + 32'd1 + k);
		end

		// timer match raises ti and an interrupt on line 7
		write_reg(cp0_pkg::REG_STATUS, 32'h0000_8001);
		write_reg(cp0_pkg::REG_COUNT, 32'd100);
		write_reg(cp0_pkg::REG_COMPARE, 32'd103);
		inter_valid = 1'b1;
		wait_intexc(20);
		read_reg(cp0_pkg::REG_CAUSE, c);
		check_bit("ti at match", c.f.ti, 1'b1);
		@(negedge clk);
		inter_valid = 1'b0;
		write_reg(cp0_pkg::REG_COMPARE, 32'hffff_0000);
		read_reg(cp0_pkg::REG_CAUSE, c);
		check_bit("ti after compare write", c.f.ti, 1'b0);

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
rtl/cp0_pkg.sv
rtl/cp0_excp_encoder.sv
rtl/cp0_int_ctrl.sv
rtl/cp0_timer.sv
rtl/cp0_regfile.sv
rtl/cp0_top.sv
testbench/cp0_sva.sv
testbench/cp0_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= cp0_tb
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
